/* common/trace_pkg.sv */
package trace_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------

    // machine word
    localparam int XLEN = 32;

    // trap nesting counter, wraps modulo 16
    localparam int TRAP_DEPTH_W = 4;

    // signed running sum of addi x2, x2, imm
    localparam int STACK_DEPTH_W = 16;

    // ----------------------------------------------------------
    // rv32i major opcodes
    // ----------------------------------------------------------

    localparam logic [6:0] OPC_LUI     = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
    localparam logic [6:0] OPC_JAL     = 7'b1101111;
    localparam logic [6:0] OPC_JALR    = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
    localparam logic [6:0] OPC_LOAD    = 7'b0000011;
    localparam logic [6:0] OPC_STORE   = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP      = 7'b0110011;
    localparam logic [6:0] OPC_MISCMEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

    // ----------------------------------------------------------
    // instruction classes
    // ----------------------------------------------------------

    typedef enum logic [3:0] {
        CLS_LUI      = 4'd0,
        CLS_AUIPC    = 4'd1,
        CLS_JAL      = 4'd2,
        CLS_JALR     = 4'd3,
        CLS_BRANCH   = 4'd4,
        CLS_LOAD     = 4'd5,
        CLS_STORE    = 4'd6,
        CLS_ALU_IMM  = 4'd7,
        CLS_ALU      = 4'd8,
        CLS_FENCEI   = 4'd9,
        CLS_CSR      = 4'd10,
        CLS_TRAP_RTN = 4'd11,
        CLS_WFI      = 4'd12,
        CLS_OTHER    = 4'd13
    } trace_class_e;

    // ----------------------------------------------------------
    // record
    // ----------------------------------------------------------

    // payload word as seen by an instruction record
    typedef struct packed {
        trace_class_e cls;
        logic         call;
        logic         ret;
        logic [2:0]   funct3;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [7:0]   zero;
    } trace_ins_view_t;

    // one word, two readings picked by the record kind
    typedef union packed {
        trace_ins_view_t   ins;
        logic [XLEN-1:0]   cause;
    } trace_payload_u;

    typedef struct packed {
        logic                     kind;
        logic [1:0]               mode;
        logic [TRAP_DEPTH_W-1:0]  trap_depth;
        logic [STACK_DEPTH_W-1:0] stack_depth;
        logic [XLEN-1:0]          addr;
        trace_payload_u           payload;
        // alu result, trap entry or trap return address
        logic [XLEN-1:0]          data;
    } trace_record_t;

endpackage

/* list.f */
common/trace_pkg.sv
source/trace_capture.sv
source/trace_fifo.sv
source/trace_serializer.sv
source/rv_trace_unit.sv
+incdir+tb
tb/rv_trace_unit_tb.sv

/* source/rv_trace_unit.sv */
`timescale 1ns/1ps

module rv_trace_unit #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                       clk_i,
    input  logic                       clk_en_i,
    input  logic                       reset_i,
    // execute stage
    input  logic                       ex_stage_en_i,
    input  logic                       execute_commit_i,
    input  logic [trace_pkg::XLEN-1:0] ins_addr_i,
    input  logic [31:0]                ins_value_i,
    input  logic [trace_pkg::XLEN-1:0] alu_dout_i,
    input  logic [1:0]                 csr_mode_i,
    // trap side
    input  logic                       csr_jump_to_trap_i,
    input  logic [trace_pkg::XLEN-1:0] csr_trap_cause_i,
    input  logic [trace_pkg::XLEN-1:0] csr_trap_entry_addr_i,
    input  logic [trace_pkg::XLEN-1:0] csr_trap_rtn_addr_i,
    // trace port
    output logic [trace_pkg::XLEN-1:0] trace_word_o,
    output logic                       trace_valid_o,
    output logic                       trace_start_o,
    output logic                       overflow_o
);

    logic                     push;
    trace_pkg::trace_record_t record;
    logic                     empty;
    logic                     pop;
    trace_pkg::trace_record_t head;

    trace_capture i_trace_capture (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .clk_en_i              (clk_en_i),
        .ex_stage_en_i         (ex_stage_en_i),
        .execute_commit_i      (execute_commit_i),
        .ins_addr_i            (ins_addr_i),
        .ins_value_i           (ins_value_i),
        .alu_dout_i            (alu_dout_i),
        .csr_mode_i            (csr_mode_i),
        .csr_jump_to_trap_i    (csr_jump_to_trap_i),
        .csr_trap_cause_i      (csr_trap_cause_i),
        .csr_trap_entry_addr_i (csr_trap_entry_addr_i),
        .csr_trap_rtn_addr_i   (csr_trap_rtn_addr_i),
        .push_o                (push),
        .record_o              (record)
    );

    trace_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_trace_fifo (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .push_i     (push),
        .record_i   (record),
        .pop_i      (pop),
        .empty_o    (empty),
        .head_o     (head),
        .overflow_o (overflow_o)
    );

    trace_serializer i_trace_serializer (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .empty_i       (empty),
        .head_i        (head),
        .pop_o         (pop),
        .trace_word_o  (trace_word_o),
        .trace_valid_o (trace_valid_o),
        .trace_start_o (trace_start_o)
    );

endmodule

/* source/trace_capture.sv */
`timescale 1ns/1ps

module trace_capture (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          clk_en_i,
    input  logic                          ex_stage_en_i,
    input  logic                          execute_commit_i,
    input  logic [trace_pkg::XLEN-1:0]    ins_addr_i,
    input  logic [31:0]                   ins_value_i,
    input  logic [trace_pkg::XLEN-1:0]    alu_dout_i,
    input  logic [1:0]                    csr_mode_i,
    input  logic                          csr_jump_to_trap_i,
    input  logic [trace_pkg::XLEN-1:0]    csr_trap_cause_i,
    input  logic [trace_pkg::XLEN-1:0]    csr_trap_entry_addr_i,
    input  logic [trace_pkg::XLEN-1:0]    csr_trap_rtn_addr_i,
    output logic                          push_o,
    output trace_pkg::trace_record_t      record_o
);

    // ----------------------------------------------------------
    // instruction fields
    // ----------------------------------------------------------

    logic [6:0]                            opcode;
    logic [2:0]                            funct3;
    logic [6:0]                            funct7;
    logic [11:0]                           funct12;
    logic [4:0]                            rd;
    logic [4:0]                            rs1;
    logic [4:0]                            rs2;
    logic [trace_pkg::XLEN-1:0]            imm_i;

    logic                                  qualify;
    logic                                  is_trap;
    logic                                  is_trap_rtn;
    logic                                  is_stack_adj;
    logic                                  sys_plain;
    trace_pkg::trace_class_e               cls;
    trace_pkg::trace_payload_u             payload;
    trace_pkg::trace_record_t              next_record;

    logic [trace_pkg::TRAP_DEPTH_W-1:0]    trap_depth;
    logic [trace_pkg::STACK_DEPTH_W-1:0]   stack_depth;
    logic [trace_pkg::STACK_DEPTH_W-1:0]   stack_step;

    assign opcode  = ins_value_i[6:0];
    assign rd      = ins_value_i[11:7];
    assign funct3  = ins_value_i[14:12];
    assign rs1     = ins_value_i[19:15];
    assign rs2     = ins_value_i[24:20];
    assign funct7  = ins_value_i[31:25];
    assign funct12 = ins_value_i[31:20];

    // i-type immediate, sign extended
    assign imm_i = {{(trace_pkg::XLEN-12){ins_value_i[31]}}, ins_value_i[31:20]};

    // trap wins over commit
    assign qualify = clk_en_i & ex_stage_en_i & (csr_jump_to_trap_i | execute_commit_i);
    assign is_trap = csr_jump_to_trap_i;

    // ecall, ebreak, xret and wfi all have rd and rs1 at zero
    assign sys_plain = (funct3 == 3'b000) && (rd == 5'd0) && (rs1 == 5'd0);

    // ----------------------------------------------------------
    // classification
    // ----------------------------------------------------------

    always_comb begin
        cls = trace_pkg::CLS_OTHER;
        case (opcode)
            trace_pkg::OPC_LUI:    cls = trace_pkg::CLS_LUI;
            trace_pkg::OPC_AUIPC:  cls = trace_pkg::CLS_AUIPC;
            trace_pkg::OPC_JAL:    cls = trace_pkg::CLS_JAL;
            trace_pkg::OPC_JALR:   cls = trace_pkg::CLS_JALR;
            trace_pkg::OPC_BRANCH: cls = trace_pkg::CLS_BRANCH;
            trace_pkg::OPC_LOAD:   cls = trace_pkg::CLS_LOAD;
            trace_pkg::OPC_STORE:  cls = trace_pkg::CLS_STORE;
            trace_pkg::OPC_OPIMM:  cls = trace_pkg::CLS_ALU_IMM;
            trace_pkg::OPC_OP: begin
                // only sub and sra use the alternate funct7
                if (funct7 == 7'b0000000) begin
                    cls = trace_pkg::CLS_ALU;
                end else if (funct7 == 7'b0100000 &&
                             (funct3 == 3'b000 || funct3 == 3'b101)) begin
                    cls = trace_pkg::CLS_ALU;
                end
            end
            trace_pkg::OPC_MISCMEM: begin
                if (funct3 == 3'b001) begin
                    cls = trace_pkg::CLS_FENCEI;
                end
            end
            trace_pkg::OPC_SYSTEM: begin
                if (funct3 != 3'b000 && funct3 != 3'b100) begin
                    cls = trace_pkg::CLS_CSR;
                end else if (sys_plain) begin
                    case (funct12)
                        // uret, sret, mret
                        12'h002, 12'h102, 12'h302: cls = trace_pkg::CLS_TRAP_RTN;
                        12'h105:                   cls = trace_pkg::CLS_WFI;
                        default:                   cls = trace_pkg::CLS_OTHER;
                    endcase
                end
            end
            default: cls = trace_pkg::CLS_OTHER;
        endcase
    end

    assign is_trap_rtn  = ~is_trap && (cls == trace_pkg::CLS_TRAP_RTN);
    assign is_stack_adj = (opcode == trace_pkg::OPC_OPIMM) && (funct3 == 3'b000) &&
                          (rd == 5'd2) && (rs1 == 5'd2);
    assign stack_step   = imm_i[trace_pkg::STACK_DEPTH_W-1:0];

    // ----------------------------------------------------------
    // record assembly
    // ----------------------------------------------------------

    always_comb begin
        payload = '0;
        if (is_trap) begin
            payload.cause = csr_trap_cause_i;
        end else begin
            payload.ins.cls    = cls;
            // jal to the link register
            payload.ins.call   = (opcode == trace_pkg::OPC_JAL) && (rd == 5'd1);
            // jalr from the link register, no offset
            payload.ins.ret    = (opcode == trace_pkg::OPC_JALR) && (rs1 == 5'd1) &&
                                 (imm_i == '0);
            payload.ins.funct3 = funct3;
            payload.ins.rd     = rd;
            payload.ins.rs1    = rs1;
            payload.ins.rs2    = rs2;
        end
    end

    always_comb begin
        next_record.kind        = is_trap;
        next_record.mode        = csr_mode_i;
        // depths before this event's own update
        next_record.trap_depth  = trap_depth;
        next_record.stack_depth = stack_depth;
        next_record.addr        = ins_addr_i;
        next_record.payload     = payload;
        if (is_trap) begin
            next_record.data = csr_trap_entry_addr_i;
        end else if (is_trap_rtn) begin
            next_record.data = csr_trap_rtn_addr_i;
        end else begin
            next_record.data = alu_dout_i;
        end
    end

    // ----------------------------------------------------------
    // depth tracking and push
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            push_o      <= 1'b0;
            trap_depth  <= '0;
            stack_depth <= '0;
        end else begin
            push_o <= qualify;
            if (qualify) begin
                if (is_trap) begin
                    trap_depth <= trap_depth + 1'b1;
                end else if (is_trap_rtn) begin
                    trap_depth <= trap_depth - 1'b1;
                end
                if (~is_trap && is_stack_adj) begin
                    stack_depth <= stack_depth + stack_step;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (qualify) begin
            record_o <= next_record;
        end
    end

endmodule

/* source/trace_fifo.sv */
`timescale 1ns/1ps

module trace_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     push_i,
    input  trace_pkg::trace_record_t record_i,
    input  logic                     pop_i,
    output logic                     empty_o,
    output trace_pkg::trace_record_t head_o,
    output logic                     overflow_o
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    trace_pkg::trace_record_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full    = (count == FIFO_DEPTH[PTR_W:0]);
    assign empty_o = (count == '0);

    // full is judged before a pop at the same edge
    assign wr_en = push_i & ~full;
    assign rd_en = pop_i & ~empty_o;

    assign head_o = mem[rd_ptr];

    // ----------------------------------------------------------
    // storage
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= record_i;
        end
    end

    // ----------------------------------------------------------
    // pointers, occupancy, overflow
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // dropped record, sticky until reset
            if (push_i & full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

/* source/trace_serializer.sv */
`timescale 1ns/1ps

module trace_serializer (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       empty_i,
    input  trace_pkg::trace_record_t   head_i,
    output logic                       pop_o,
    output logic [trace_pkg::XLEN-1:0] trace_word_o,
    output logic                       trace_valid_o,
    output logic                       trace_start_o
);

    // word currently on the port
    logic [1:0]               word_cnt;
    logic                     busy;
    trace_pkg::trace_record_t rec;
    logic [trace_pkg::XLEN-1:0] header;

    // take the next record when idle or on the last word
    assign pop_o = (~busy | (word_cnt == 2'd3)) & ~empty_i;

    // ----------------------------------------------------------
    // sequencing
    // ----------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            busy     <= 1'b0;
            word_cnt <= 2'd0;
        end else if (pop_o) begin
            busy     <= 1'b1;
            word_cnt <= 2'd0;
        end else if (busy) begin
            if (word_cnt == 2'd3) begin
                // nothing queued behind
                busy <= 1'b0;
            end
            word_cnt <= word_cnt + 1'b1;
        end
    end

    // record whose words are on the port
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            rec <= head_i;
        end
    end

    // ----------------------------------------------------------
    // word select
    // ----------------------------------------------------------

    // kind, mode and trap depth on top and stack depth at the bottom
    assign header = {rec.kind,
                     rec.mode,
                     rec.trap_depth,
                     9'd0,
                     rec.stack_depth};

    always_comb begin
        case (word_cnt)
            2'd0:    trace_word_o = header;
            2'd1:    trace_word_o = rec.addr;
            2'd2:    trace_word_o = rec.payload;
            default: trace_word_o = rec.data;
        endcase
    end

    assign trace_valid_o = busy;
    assign trace_start_o = busy & (word_cnt == 2'd0);

endmodule

/* tb/trace_tb_model.svh */
`ifndef TRACE_TB_MODEL_SVH
`define TRACE_TB_MODEL_SVH

// ------------------------------------------------------------
// random source
// ------------------------------------------------------------

logic [31:0] lfsr = 32'h90d5_c386;

// one galois step per bit taken, newest bit at the bottom
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        v = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

// ------------------------------------------------------------
// encodings
// ------------------------------------------------------------

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

// addi x2, x2, random immediate
function automatic logic [31:0] addi_sp_rand();
    logic [31:0] r;
    r = rand_bits(12);
    return enc_i(r[11:0], 5'd2, 3'd0, 5'd2, trace_pkg::OPC_OPIMM);
endfunction

// ------------------------------------------------------------
// reference model
// ------------------------------------------------------------

logic [3:0]   m_trap = '0;
logic [15:0]  m_stack = '0;
// header, address, payload, data, in port order
logic [127:0] exp_q [$];

function automatic void model_event(input bit trap, input logic [31:0] ins,
                                    input logic [3:0] cls, input logic [31:0] addr,
                                    input logic [1:0] mode, input logic [31:0] alu,
                                    input logic [31:0] cause, input logic [31:0] entry,
                                    input logic [31:0] rtn);
    logic [31:0] hdr;
    logic [31:0] pay;
    logic [31:0] data;
    logic        call;
    logic        ret;
    call = (ins[6:0] == trace_pkg::OPC_JAL) && (ins[11:7] == 5'd1);
    ret  = (ins[6:0] == trace_pkg::OPC_JALR) && (ins[19:15] == 5'd1) && (ins[31:20] == 12'd0);
    hdr  = {trap, mode, m_trap, 9'd0, m_stack};
    pay  = trap ? cause : {cls, call, ret, ins[14:12], ins[11:7], ins[19:15], ins[24:20], 8'd0};
    data = trap ? entry : ((cls == trace_pkg::CLS_TRAP_RTN) ? rtn : alu);
    exp_q.push_back({hdr, addr, pay, data});
    if (trap) begin
        m_trap = m_trap + 4'd1;
    end else if (cls == trace_pkg::CLS_TRAP_RTN) begin
        m_trap = m_trap - 4'd1;
    end
    if (!trap && ins[6:0] == trace_pkg::OPC_OPIMM && ins[14:12] == 3'd0 &&
        ins[11:7] == 5'd2 && ins[19:15] == 5'd2) begin
        m_stack = m_stack + {{4{ins[31]}}, ins[31:20]};
    end
endfunction

`endif

/* tb/rv_trace_unit_tb.sv */
`timescale 1ns/1ps

module rv_trace_unit_tb;

    localparam int FIFO_DEPTH  = 8;
    localparam int N_RAND      = 40;
    localparam int N_STACK     = 12;
    localparam int N_TOTAL     = N_RAND + 2 + N_STACK + 6 + 4 * FIFO_DEPTH + 1;
    // trace port time per record plus reset, quiet phase, gaps and drains
    localparam int WATCHDOG_NS = 80 * (N_TOTAL + FIFO_DEPTH) + 20 * (46 + 2 * N_TOTAL) + 2000;

    logic        clk_i = 1'b0;
    logic        clk_en_i, reset_i, ex_stage_en_i, execute_commit_i, csr_jump_to_trap_i;
    logic [31:0] ins_addr_i, ins_value_i, alu_dout_i;
    logic [31:0] csr_trap_cause_i, csr_trap_entry_addr_i, csr_trap_rtn_addr_i;
    logic [1:0]  csr_mode_i;
    logic [31:0] trace_word_o;
    logic        trace_valid_o, trace_start_o, overflow_o;

    logic         quiet = 1'b1;
    logic         burst_on = 1'b0;
    logic         allow_drop = 1'b0;
    logic         rec_seen = 1'b0;
    logic         rec_ok = 1'b0;
    logic [127:0] shift = '0;
    logic [31:0]  pc = 32'h8000_0000;
    int           widx = 0;
    int           n_checked = 0;
    int           mismatch_errs = 0;
    int           other_errs = 0;

    `include "trace_tb_model.svh"

    rv_trace_unit #(.FIFO_DEPTH(FIFO_DEPTH)) i_rv_trace_unit (.*);

    initial begin
        forever #10 clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS * 1ns);
        $display("timeout: trace port did not finish within %0d ns", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // collector of four words from each start
    // ------------------------------------------------------------

    always @(posedge clk_i) begin : collect
        logic [127:0] rec;
        rec_seen <= 1'b0;
        if (!reset_i && trace_valid_o) begin
            widx  = trace_start_o ? 0 : widx + 1;
            shift = {shift[95:0], trace_word_o};
            if (widx == 3) begin
                rec = shift;
                // records lost on overflow are skipped while order holds
                while (allow_drop && exp_q.size() > 0 && exp_q[0] != rec) begin
                    void'(exp_q.pop_front());
                end
                rec_ok <= (exp_q.size() > 0) ? (exp_q[0] == rec) : 1'b0;
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                end
                rec_seen <= 1'b1;
                n_checked++;
            end
        end
    end

    a_record: assert property (@(posedge clk_i) disable iff (reset_i) rec_seen |-> rec_ok)
        else begin
            mismatch_errs++;
            $display("mismatch at %0t: trace record %0d differs from the model",
                     $time, n_checked);
        end
    a_quiet: assert property (@(posedge clk_i) disable iff (reset_i)
                              quiet |-> !trace_valid_o && !trace_start_o)
        else begin
            other_errs++;
            $display("trace port active at %0t while tracing was disabled", $time);
        end
    a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
                                    !burst_on |-> !overflow_o)
        else begin
            other_errs++;
            $display("overflow raised at %0t without a burst", $time);
        end
    a_sticky: assert property (@(posedge clk_i) disable iff (reset_i) overflow_o |=> overflow_o)
        else begin
            other_errs++;
            $display("overflow dropped at %0t before reset", $time);
        end
    a_four_words: assert property (@(posedge clk_i) disable iff (reset_i)
                                   trace_start_o |-> trace_valid_o [*4])
        else begin
            other_errs++;
            $display("record at %0t was not sent as four consecutive words", $time);
        end

    // ------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------

    task automatic issue(input bit trap, input bit commit, input logic [31:0] ins,
                         input logic [3:0] cls);
        logic [31:0] alu, cause, entry, rtn;
        logic [1:0]  mode;
        alu   = rand_bits(32);
        cause = rand_bits(32);
        entry = rand_bits(30) << 2;
        rtn   = rand_bits(30) << 2;
        mode  = 2'(rand_bits(2));
        @(posedge clk_i);
        ex_stage_en_i         <= 1'b1;
        execute_commit_i      <= commit;
        csr_jump_to_trap_i    <= trap;
        ins_value_i           <= ins;
        ins_addr_i            <= pc;
        alu_dout_i            <= alu;
        csr_mode_i            <= mode;
        csr_trap_cause_i      <= cause;
        csr_trap_entry_addr_i <= entry;
        csr_trap_rtn_addr_i   <= rtn;
        model_event(trap, ins, cls, pc, mode, alu, cause, entry, rtn);
        pc = pc + 32'd4;
    endtask

    task automatic gap(input int n);
        @(posedge clk_i);
        execute_commit_i   <= 1'b0;
        csr_jump_to_trap_i <= 1'b0;
        repeat (n - 1) @(posedge clk_i);
    endtask

    // wait until the port has been idle for eight cycles
    task automatic drain(input bit strict);
        int idle;
        idle = 0;
        gap(1);
        while (idle < 8) begin
            @(posedge clk_i);
            idle = trace_valid_o ? 0 : idle + 1;
        end
        assert (!strict || exp_q.size() == 0) else begin
            other_errs++;
            $display("%0d expected records never appeared on the trace port", exp_q.size());
        end
    endtask

    function automatic void random_ins(output logic [31:0] ins, output logic [3:0] cls);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = rand_bits(32);
        f3 = r[14:12];
        case (rand_bits(4) % 10)
            0: begin
                ins = {r[31:7], trace_pkg::OPC_LUI};
                cls = trace_pkg::CLS_LUI;
            end
            1: begin
                ins = {r[31:7], trace_pkg::OPC_AUIPC};
                cls = trace_pkg::CLS_AUIPC;
            end
            2: begin
                // sub and sra are the only alternate forms
                f7  = ((f3 == 3'd0 || f3 == 3'd5) && r[30]) ? 7'h20 : 7'h00;
                ins = {f7, r[24:7], trace_pkg::OPC_OP};
                cls = trace_pkg::CLS_ALU;
            end
            3: begin
                ins = {r[31:7], trace_pkg::OPC_OPIMM};
                cls = trace_pkg::CLS_ALU_IMM;
            end
            4: begin
                ins = {r[31:7], trace_pkg::OPC_BRANCH};
                cls = trace_pkg::CLS_BRANCH;
            end
            5: begin
                ins = {r[31:7], trace_pkg::OPC_LOAD};
                cls = trace_pkg::CLS_LOAD;
            end
            6: begin
                ins = {r[31:7], trace_pkg::OPC_STORE};
                cls = trace_pkg::CLS_STORE;
            end
            7: begin
                f3  = (r[13:12] == 2'd0) ? {r[14], 2'b01} : r[14:12];
                ins = {r[31:15], f3, r[11:7], trace_pkg::OPC_SYSTEM};
                cls = trace_pkg::CLS_CSR;
            end
            8: begin
                ins = {r[31:15], 3'b001, r[11:7], trace_pkg::OPC_MISCMEM};
                cls = trace_pkg::CLS_FENCEI;
            end
            default: begin
                ins = 32'h1050_0073;
                cls = trace_pkg::CLS_WFI;
            end
        endcase
    endfunction

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------

    initial begin
        logic [31:0] ins;
        logic [31:0] r;
        logic [3:0]  cls;
        {clk_en_i, ex_stage_en_i, execute_commit_i, csr_jump_to_trap_i} = 4'b1000;
        {ins_addr_i, ins_value_i, alu_dout_i, csr_mode_i} = '0;
        {csr_trap_cause_i, csr_trap_entry_addr_i, csr_trap_rtn_addr_i} = '0;
        reset_i = 1'b1;
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;

        // strobes raised while the stage or the clock enable is off
        repeat (4) @(posedge clk_i);
        clk_en_i           <= 1'b0;
        ex_stage_en_i      <= 1'b1;
        execute_commit_i   <= 1'b1;
        csr_jump_to_trap_i <= 1'b1;
        repeat (4) @(posedge clk_i);
        clk_en_i      <= 1'b1;
        ex_stage_en_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        execute_commit_i   <= 1'b0;
        csr_jump_to_trap_i <= 1'b0;
        repeat (6) @(posedge clk_i);
        quiet <= 1'b0;

        for (int i = 0; i < N_RAND; i++) begin
            random_ins(ins, cls);
            issue(1'b0, 1'b1, ins, cls);
            gap(4);
        end
        drain(1'b1);

        // call and return followed by stack adjustments
        r = rand_bits(20);
        issue(1'b0, 1'b1, {r[19:0], 5'd1, trace_pkg::OPC_JAL}, trace_pkg::CLS_JAL);
        gap(4);
        ins = enc_i(12'd0, 5'd1, 3'd0, 5'd0, trace_pkg::OPC_JALR);
        issue(1'b0, 1'b1, ins, trace_pkg::CLS_JALR);
        gap(4);
        for (int i = 0; i < N_STACK; i++) begin
            issue(1'b0, 1'b1, addi_sp_rand(), trace_pkg::CLS_ALU_IMM);
            gap(4);
        end
        drain(1'b1);

        // nested traps with commit also high on the middle one
        issue(1'b1, 1'b0, rand_bits(32), trace_pkg::CLS_OTHER);
        gap(4);
        ins = enc_i(12'h010, 5'd2, 3'd0, 5'd2, trace_pkg::OPC_OPIMM);
        issue(1'b1, 1'b1, ins, trace_pkg::CLS_OTHER);
        gap(4);
        issue(1'b1, 1'b0, rand_bits(32), trace_pkg::CLS_OTHER);
        gap(4);
        issue(1'b0, 1'b1, 32'h3020_0073, trace_pkg::CLS_TRAP_RTN);
        gap(4);
        issue(1'b0, 1'b1, 32'h1020_0073, trace_pkg::CLS_TRAP_RTN);
        gap(4);
        issue(1'b0, 1'b1, 32'h0020_0073, trace_pkg::CLS_TRAP_RTN);
        drain(1'b1);

        // back to back burst overruns the fifo
        burst_on   = 1'b1;
        allow_drop = 1'b1;
        for (int i = 0; i < 4 * FIFO_DEPTH; i++) begin
            issue(1'b0, 1'b1, addi_sp_rand(), trace_pkg::CLS_ALU_IMM);
        end
        drain(1'b0);
        assert (overflow_o) else begin
            other_errs++;
            $display("overflow never raised during the burst");
        end
        exp_q.delete();
        allow_drop = 1'b0;
        // stack depth must include the dropped updates
        issue(1'b0, 1'b1, addi_sp_rand(), trace_pkg::CLS_ALU_IMM);
        drain(1'b1);

        $display("errors: %0d mismatches, %0d other failures, %0d records checked",
                 mismatch_errs, other_errs, n_checked);
        if (mismatch_errs + other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
